// File: verilog/mips_pkg.sv
package mips_pkg;

    // one instruction word in three field layouts
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] sa;
            logic [5:0] funct;
        } r_fmt;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm16;
        } i_fmt;
        struct packed {
            logic [5:0]  opcode;
            logic [25:0] instr_index;
        } j_fmt;
    } instr_t;

    // alu_op bit positions
    localparam int ALU_ADD  = 11;
    localparam int ALU_SUB  = 10;
    localparam int ALU_SLT  = 9;
    localparam int ALU_SLTU = 8;
    localparam int ALU_AND  = 7;
    localparam int ALU_NOR  = 6;
    localparam int ALU_OR   = 5;
    localparam int ALU_XOR  = 4;
    localparam int ALU_SLL  = 3;
    localparam int ALU_SRL  = 2;
    localparam int ALU_SRA  = 1;
    localparam int ALU_LUI  = 0;

    // br_op bit positions
    localparam int BR_BEQ    = 11;
    localparam int BR_BNE    = 10;
    localparam int BR_BGEZ   = 9;
    localparam int BR_BGTZ   = 8;
    localparam int BR_BLEZ   = 7;
    localparam int BR_BLTZ   = 6;
    localparam int BR_BGEZAL = 5;
    localparam int BR_BLTZAL = 4;
    localparam int BR_J      = 3;
    localparam int BR_JAL    = 2;
    localparam int BR_JR     = 1;
    localparam int BR_JALR   = 0;

    // operand select bit positions
    localparam int SRC1_RS    = 0;
    localparam int SRC1_PC    = 1;
    localparam int SRC1_SA    = 2;
    localparam int SRC2_RT    = 0;
    localparam int SRC2_SIMM  = 1;
    localparam int SRC2_EIGHT = 2;
    localparam int SRC2_ZIMM  = 3;

    localparam logic [31:0] RESET_PC = 32'h0000_0000;
    localparam logic [4:0]  LINK_REG = 5'd31;

    // core_ctrl states
    localparam logic [1:0] ST_FETCH = 2'd0;
    localparam logic [1:0] ST_EXEC  = 2'd1;
    localparam logic [1:0] ST_MEM   = 2'd2;
    localparam logic [1:0] ST_WB    = 2'd3;

endpackage

// File: verilog/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder
    import mips_pkg::*;
(
    input  instr_t      inst_i,
    output logic [11:0] alu_op_o,
    output logic [2:0]  sel_alu_src1_o,
    output logic [3:0]  sel_alu_src2_o,
    output logic [11:0] br_op_o,
    output logic        data_ram_en_o,
    output logic [3:0]  data_ram_wen_o,
    output logic        rf_we_o,
    output logic [4:0]  rf_waddr_o,
    output logic        sel_rf_res_o,
    output logic        halt_o
);

    logic [5:0] opcode;
    logic [5:0] funct;
    logic [4:0] rt;
    logic       special;
    logic       regimm;

    logic inst_add, inst_addu, inst_sub, inst_subu, inst_slt, inst_sltu;
    logic inst_and, inst_or, inst_xor, inst_nor;
    logic inst_sll, inst_srl, inst_sra, inst_sllv, inst_srlv, inst_srav;
    logic inst_addi, inst_addiu, inst_slti, inst_sltiu;
    logic inst_andi, inst_ori, inst_xori, inst_lui, inst_lw, inst_sw;
    logic inst_beq, inst_bne, inst_bgez, inst_bgtz, inst_blez, inst_bltz;
    logic inst_bgezal, inst_bltzal, inst_j, inst_jal, inst_jr, inst_jalr;
    logic inst_break;

    logic r_alu;
    logic shift_fix;
    logic i_simm;
    logic i_zimm;
    logic link;

    assign opcode  = inst_i.j_fmt.opcode;
    assign funct   = inst_i.r_fmt.funct;
    assign rt      = inst_i.i_fmt.rt;
    assign special = (opcode == 6'b00_0000);
    assign regimm  = (opcode == 6'b00_0001);

    assign inst_add    = special & (funct == 6'b10_0000);
    assign inst_addu   = special & (funct == 6'b10_0001);
    assign inst_sub    = special & (funct == 6'b10_0010);
    assign inst_subu   = special & (funct == 6'b10_0011);
    assign inst_and    = special & (funct == 6'b10_0100);
    assign inst_or     = special & (funct == 6'b10_0101);
    assign inst_xor    = special & (funct == 6'b10_0110);
    assign inst_nor    = special & (funct == 6'b10_0111);
    assign inst_slt    = special & (funct == 6'b10_1010);
    assign inst_sltu   = special & (funct == 6'b10_1011);
    assign inst_sll    = special & (funct == 6'b00_0000);
    assign inst_srl    = special & (funct == 6'b00_0010);
    assign inst_sra    = special & (funct == 6'b00_0011);
    assign inst_sllv   = special & (funct == 6'b00_0100);
    assign inst_srlv   = special & (funct == 6'b00_0110);
    assign inst_srav   = special & (funct == 6'b00_0111);
    assign inst_jr     = special & (funct == 6'b00_1000);
    assign inst_jalr   = special & (funct == 6'b00_1001);
    assign inst_break  = special & (funct == 6'b00_1101);

    assign inst_bltz   = regimm & (rt == 5'b0_0000);
    assign inst_bgez   = regimm & (rt == 5'b0_0001);
    assign inst_bltzal = regimm & (rt == 5'b1_0000);
    assign inst_bgezal = regimm & (rt == 5'b1_0001);

    assign inst_j      = (opcode == 6'b00_0010);
    assign inst_jal    = (opcode == 6'b00_0011);
    assign inst_beq    = (opcode == 6'b00_0100);
    assign inst_bne    = (opcode == 6'b00_0101);
    assign inst_blez   = (opcode == 6'b00_0110);
    assign inst_bgtz   = (opcode == 6'b00_0111);
    assign inst_addi   = (opcode == 6'b00_1000);
    assign inst_addiu  = (opcode == 6'b00_1001);
    assign inst_slti   = (opcode == 6'b00_1010);
    assign inst_sltiu  = (opcode == 6'b00_1011);
    assign inst_andi   = (opcode == 6'b00_1100);
    assign inst_ori    = (opcode == 6'b00_1101);
    assign inst_xori   = (opcode == 6'b00_1110);
    assign inst_lui    = (opcode == 6'b00_1111);
    assign inst_lw     = (opcode == 6'b10_0011);
    assign inst_sw     = (opcode == 6'b10_1011);

    // instruction groups sharing operand routing
    assign shift_fix = inst_sll | inst_srl | inst_sra;
    assign r_alu     = inst_add | inst_addu | inst_sub | inst_subu | inst_slt | inst_sltu
                     | inst_and | inst_or | inst_xor | inst_nor
                     | inst_sllv | inst_srlv | inst_srav | shift_fix;
    assign i_simm    = inst_addi | inst_addiu | inst_slti | inst_sltiu
                     | inst_lw | inst_sw | inst_lui;
    assign i_zimm    = inst_andi | inst_ori | inst_xori;
    assign link      = inst_jal | inst_bgezal | inst_bltzal | inst_jalr;

    assign sel_alu_src1_o[SRC1_RS] = (r_alu & ~shift_fix) | (i_simm & ~inst_lui) | i_zimm;
    assign sel_alu_src1_o[SRC1_PC] = link;
    assign sel_alu_src1_o[SRC1_SA] = shift_fix;

    assign sel_alu_src2_o[SRC2_RT]    = r_alu;
    assign sel_alu_src2_o[SRC2_SIMM]  = i_simm;
    assign sel_alu_src2_o[SRC2_EIGHT] = link;
    assign sel_alu_src2_o[SRC2_ZIMM]  = i_zimm;

    // link address is pc plus 8 through the adder
    assign alu_op_o[ALU_ADD]  = inst_add | inst_addu | inst_addi | inst_addiu
                              | inst_lw | inst_sw | link;
    assign alu_op_o[ALU_SUB]  = inst_sub | inst_subu;
    assign alu_op_o[ALU_SLT]  = inst_slt | inst_slti;
    assign alu_op_o[ALU_SLTU] = inst_sltu | inst_sltiu;
    assign alu_op_o[ALU_AND]  = inst_and | inst_andi;
    assign alu_op_o[ALU_NOR]  = inst_nor;
    assign alu_op_o[ALU_OR]   = inst_or | inst_ori;
    assign alu_op_o[ALU_XOR]  = inst_xor | inst_xori;
    assign alu_op_o[ALU_SLL]  = inst_sll | inst_sllv;
    assign alu_op_o[ALU_SRL]  = inst_srl | inst_srlv;
    assign alu_op_o[ALU_SRA]  = inst_sra | inst_srav;
    assign alu_op_o[ALU_LUI]  = inst_lui;

    assign br_op_o = {inst_beq, inst_bne, inst_bgez, inst_bgtz, inst_blez, inst_bltz,
                      inst_bgezal, inst_bltzal, inst_j, inst_jal, inst_jr, inst_jalr};

    assign data_ram_en_o  = inst_lw | inst_sw;
    assign data_ram_wen_o = {4{inst_sw}};

    assign rf_we_o    = r_alu | (i_simm & ~inst_sw) | i_zimm | link;
    // jalr links into rd and the other links into r31
    assign rf_waddr_o = ({5{r_alu | inst_jalr}} & inst_i.r_fmt.rd)
                      | ({5{(i_simm & ~inst_sw) | i_zimm}} & rt)
                      | ({5{inst_jal | inst_bgezal | inst_bltzal}} & LINK_REG);

    assign sel_rf_res_o = inst_lw;
    assign halt_o       = inst_break;

endmodule

// File: verilog/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  logic [4:0]  raddr1_i,
    input  logic [4:0]  raddr2_i,
    input  logic        we_i,
    input  logic [4:0]  waddr_i,
    input  logic [31:0] wdata_i,
    output logic [31:0] rdata1_o,
    output logic [31:0] rdata2_o
);

    logic [31:0] regs [32];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (we_i && (waddr_i != 5'd0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // r0 reads as zero
    assign rdata1_o = (raddr1_i == 5'd0) ? 32'd0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == 5'd0) ? 32'd0 : regs[raddr2_i];

endmodule

// File: verilog/alu.sv
`timescale 1ns/1ps

module alu
    import mips_pkg::*;
(
    input  logic [11:0] alu_op_i,
    input  logic [2:0]  sel_src1_i,
    input  logic [3:0]  sel_src2_i,
    input  instr_t      inst_i,
    input  logic [31:0] pc_i,
    input  logic [31:0] rs_val_i,
    input  logic [31:0] rt_val_i,
    output logic [31:0] result_o
);

    logic [31:0] op1;
    logic [31:0] op2;
    logic [15:0] imm;
    logic [4:0]  shamt;

    assign imm = inst_i.i_fmt.imm16;

    assign op1 = ({32{sel_src1_i[SRC1_RS]}} & rs_val_i)
               | ({32{sel_src1_i[SRC1_PC]}} & pc_i)
               | ({32{sel_src1_i[SRC1_SA]}} & {27'd0, inst_i.r_fmt.sa});

    assign op2 = ({32{sel_src2_i[SRC2_RT]}}    & rt_val_i)
               | ({32{sel_src2_i[SRC2_SIMM]}}  & {{16{imm[15]}}, imm})
               | ({32{sel_src2_i[SRC2_EIGHT]}} & 32'd8)
               | ({32{sel_src2_i[SRC2_ZIMM]}}  & {16'd0, imm});

    // shift amount comes from sa or low bits of rs
    assign shamt = op1[4:0];

    assign result_o = ({32{alu_op_i[ALU_ADD]}}  & (op1 + op2))
                    | ({32{alu_op_i[ALU_SUB]}}  & (op1 - op2))
                    | ({32{alu_op_i[ALU_SLT]}}  & {31'd0, $signed(op1) < $signed(op2)})
                    | ({32{alu_op_i[ALU_SLTU]}} & {31'd0, op1 < op2})
                    | ({32{alu_op_i[ALU_AND]}}  & (op1 & op2))
                    | ({32{alu_op_i[ALU_NOR]}}  & ~(op1 | op2))
                    | ({32{alu_op_i[ALU_OR]}}   & (op1 | op2))
                    | ({32{alu_op_i[ALU_XOR]}}  & (op1 ^ op2))
                    | ({32{alu_op_i[ALU_SLL]}}  & (op2 << shamt))
                    | ({32{alu_op_i[ALU_SRL]}}  & (op2 >> shamt))
                    | ({32{alu_op_i[ALU_SRA]}}  & 32'($signed(op2) >>> shamt))
                    | ({32{alu_op_i[ALU_LUI]}}  & {op2[15:0], 16'd0});

endmodule

// File: verilog/branch_unit.sv
`timescale 1ns/1ps

module branch_unit
    import mips_pkg::*;
(
    input  logic [11:0] br_op_i,
    input  instr_t      inst_i,
    input  logic [31:0] npc_i,
    input  logic [31:0] rs_val_i,
    input  logic [31:0] rt_val_i,
    output logic        taken_o,
    output logic [31:0] target_o
);

    logic        eq;
    logic        neg;
    logic        zero;
    logic        cond_br;
    logic        cond_taken;
    logic        jump_abs;
    logic [15:0] imm;

    assign imm  = inst_i.i_fmt.imm16;
    assign eq   = (rs_val_i == rt_val_i);
    assign neg  = rs_val_i[31];
    assign zero = (rs_val_i == 32'd0);

    assign cond_br  = |br_op_i[BR_BEQ:BR_BLTZAL];
    assign jump_abs = br_op_i[BR_J] | br_op_i[BR_JAL];

    assign cond_taken = (br_op_i[BR_BEQ] & eq)
                      | (br_op_i[BR_BNE] & ~eq)
                      | ((br_op_i[BR_BGEZ] | br_op_i[BR_BGEZAL]) & ~neg)
                      | (br_op_i[BR_BGTZ] & ~neg & ~zero)
                      | (br_op_i[BR_BLEZ] & (neg | zero))
                      | ((br_op_i[BR_BLTZ] | br_op_i[BR_BLTZAL]) & neg);

    // jumps are always taken
    assign taken_o = cond_taken | (|br_op_i[BR_J:BR_JALR]);

    // relative to the delay slot address
    assign target_o = ({32{cond_br}}  & (npc_i + {{14{imm[15]}}, imm, 2'b00}))
                    | ({32{jump_abs}} & {npc_i[31:28], inst_i.j_fmt.instr_index, 2'b00})
                    | ({32{br_op_i[BR_JR] | br_op_i[BR_JALR]}} & rs_val_i);

endmodule

// File: verilog/core_ctrl.sv
`timescale 1ns/1ps

module core_ctrl
    import mips_pkg::*;
(
    input  logic        clk_i,
    input  logic        arst_n_i,
    output logic        wb_cyc_o,
    output logic        wb_stb_o,
    output logic        wb_we_o,
    output logic [31:0] wb_adr_o,
    output logic [31:0] wb_dat_o,
    output logic [3:0]  wb_sel_o,
    input  logic [31:0] wb_dat_i,
    input  logic        wb_ack_i,
    input  logic        data_ram_en_i,
    input  logic [3:0]  data_ram_wen_i,
    input  logic        rf_we_i,
    input  logic [4:0]  rf_waddr_i,
    input  logic        sel_rf_res_i,
    input  logic        halt_i,
    input  logic [31:0] alu_res_i,
    input  logic        br_taken_i,
    input  logic [31:0] br_target_i,
    input  logic [31:0] rt_val_i,
    output instr_t      inst_o,
    output logic [31:0] pc_o,
    output logic [31:0] npc_o,
    output logic        rf_we_o,
    output logic [4:0]  rf_waddr_o,
    output logic [31:0] rf_wdata_o,
    output logic        halted_o
);

    logic [1:0]  state_q;
    logic [31:0] ld_data_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q  <= ST_FETCH;
            wb_cyc_o <= 1'b0;
            wb_we_o  <= 1'b0;
            halted_o <= 1'b0;
            pc_o     <= RESET_PC;
            npc_o    <= RESET_PC + 32'd4;
        end else begin
            case (state_q)
                ST_FETCH: begin
                    // only the first fetch after reset is issued here
                    if (!wb_cyc_o) begin
                        wb_cyc_o <= ~halted_o;
                    end else if (wb_ack_i) begin
                        wb_cyc_o <= 1'b0;
                        state_q  <= ST_EXEC;
                    end
                end
                ST_EXEC: begin
                    if (data_ram_en_i) begin
                        wb_cyc_o <= 1'b1;
                        wb_we_o  <= |data_ram_wen_i;
                        state_q  <= ST_MEM;
                    end else begin
                        state_q <= ST_WB;
                    end
                end
                ST_MEM: begin
                    if (wb_ack_i) begin
                        wb_cyc_o <= 1'b0;
                        wb_we_o  <= 1'b0;
                        state_q  <= ST_WB;
                    end
                end
                default: begin
                    // pc follows npc one instruction late for the delay slot
                    pc_o     <= npc_o;
                    npc_o    <= br_taken_i ? br_target_i : npc_o + 32'd4;
                    halted_o <= halt_i;
                    wb_cyc_o <= ~halt_i;
                    state_q  <= ST_FETCH;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if ((state_q == ST_FETCH) && wb_cyc_o && wb_ack_i) begin
            inst_o <= wb_dat_i;
        end
        if ((state_q == ST_MEM) && wb_ack_i) begin
            ld_data_q <= wb_dat_i;
        end
    end

    assign wb_stb_o = wb_cyc_o;
    assign wb_adr_o = (state_q == ST_MEM) ? alu_res_i : pc_o;
    assign wb_dat_o = rt_val_i;
    assign wb_sel_o = wb_we_o ? data_ram_wen_i : 4'b1111;

    assign rf_we_o    = (state_q == ST_WB) & rf_we_i;
    assign rf_waddr_o = rf_waddr_i;
    assign rf_wdata_o = sel_rf_res_i ? ld_data_q : alu_res_i;

endmodule

// File: verilog/mips_core.sv
`timescale 1ns/1ps

module mips_core
    import mips_pkg::*;
(
    input  logic        clk_i,
    input  logic        arst_n_i,
    output logic        wb_cyc_o,
    output logic        wb_stb_o,
    output logic        wb_we_o,
    output logic [31:0] wb_adr_o,
    output logic [31:0] wb_dat_o,
    output logic [3:0]  wb_sel_o,
    input  logic [31:0] wb_dat_i,
    input  logic        wb_ack_i,
    output logic        halted_o
);

    instr_t      inst;
    logic [31:0] pc;
    logic [31:0] npc;
    logic [11:0] alu_op;
    logic [2:0]  sel_src1;
    logic [3:0]  sel_src2;
    logic [11:0] br_op;
    logic        data_ram_en;
    logic [3:0]  data_ram_wen;
    logic        dec_rf_we;
    logic [4:0]  dec_rf_waddr;
    logic        sel_rf_res;
    logic        halt;
    logic [31:0] rs_val;
    logic [31:0] rt_val;
    logic [31:0] alu_res;
    logic        br_taken;
    logic [31:0] br_target;
    logic        rf_we;
    logic [4:0]  rf_waddr;
    logic [31:0] rf_wdata;

    core_ctrl u_core_ctrl (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .wb_cyc_o       (wb_cyc_o),
        .wb_stb_o       (wb_stb_o),
        .wb_we_o        (wb_we_o),
        .wb_adr_o       (wb_adr_o),
        .wb_dat_o       (wb_dat_o),
        .wb_sel_o       (wb_sel_o),
        .wb_dat_i       (wb_dat_i),
        .wb_ack_i       (wb_ack_i),
        .data_ram_en_i  (data_ram_en),
        .data_ram_wen_i (data_ram_wen),
        .rf_we_i        (dec_rf_we),
        .rf_waddr_i     (dec_rf_waddr),
        .sel_rf_res_i   (sel_rf_res),
        .halt_i         (halt),
        .alu_res_i      (alu_res),
        .br_taken_i     (br_taken),
        .br_target_i    (br_target),
        .rt_val_i       (rt_val),
        .inst_o         (inst),
        .pc_o           (pc),
        .npc_o          (npc),
        .rf_we_o        (rf_we),
        .rf_waddr_o     (rf_waddr),
        .rf_wdata_o     (rf_wdata),
        .halted_o       (halted_o)
    );

    inst_decoder u_inst_decoder (
        .inst_i         (inst),
        .alu_op_o       (alu_op),
        .sel_alu_src1_o (sel_src1),
        .sel_alu_src2_o (sel_src2),
        .br_op_o        (br_op),
        .data_ram_en_o  (data_ram_en),
        .data_ram_wen_o (data_ram_wen),
        .rf_we_o        (dec_rf_we),
        .rf_waddr_o     (dec_rf_waddr),
        .sel_rf_res_o   (sel_rf_res),
        .halt_o         (halt)
    );

    regfile u_regfile (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .raddr1_i (inst.r_fmt.rs),
        .raddr2_i (inst.r_fmt.rt),
        .we_i     (rf_we),
        .waddr_i  (rf_waddr),
        .wdata_i  (rf_wdata),
        .rdata1_o (rs_val),
        .rdata2_o (rt_val)
    );

    alu u_alu (
        .alu_op_i   (alu_op),
        .sel_src1_i (sel_src1),
        .sel_src2_i (sel_src2),
        .inst_i     (inst),
        .pc_i       (pc),
        .rs_val_i   (rs_val),
        .rt_val_i   (rt_val),
        .result_o   (alu_res)
    );

    branch_unit u_branch_unit (
        .br_op_i  (br_op),
        .inst_i   (inst),
        .npc_i    (npc),
        .rs_val_i (rs_val),
        .rt_val_i (rt_val),
        .taken_o  (br_taken),
        .target_o (br_target)
    );

endmodule

// File: tests/tb_mips_core.sv
`timescale 1ns/1ps

module tb_mips_core;

    localparam int CLK_PERIOD = 4;

    logic        clk;
    logic        arst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_adr;
    logic [31:0] wb_dat_w;
    logic [3:0]  wb_sel;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic        halted;

    logic [31:0] mem [1024];
    logic [31:0] prog [$];
    logic [31:0] wlog_adr [$];
    logic [31:0] wlog_dat [$];
    logic [3:0]  wlog_sel [$];
    integer      seed;
    int          errors;
    int          cycle_cnt;
    int          budget;
    int          bus_cycles;
    int          wait_cnt;
    logic        busy;
    logic        waits_en;
    logic        first_seen;
    logic [31:0] first_adr;

    mips_core u_mips_core (
        .clk_i    (clk),
        .arst_n_i (arst_n),
        .wb_cyc_o (wb_cyc),
        .wb_stb_o (wb_stb),
        .wb_we_o  (wb_we),
        .wb_adr_o (wb_adr),
        .wb_dat_o (wb_dat_w),
        .wb_sel_o (wb_sel),
        .wb_dat_i (wb_dat_r),
        .wb_ack_i (wb_ack),
        .halted_o (halted)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // wishbone slave answering a little after each edge
    always @(posedge clk) begin
        #1;
        if (wb_ack) begin
            wb_ack = 1'b0;
            busy   = 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!busy) begin
                busy = 1'b1;
                bus_cycles++;
                if (!first_seen) begin
                    first_seen = 1'b1;
                    first_adr  = wb_adr;
                end
                wait_cnt = waits_en ? int'($unsigned($random(seed)) % 4) : 0;
            end
            if (wait_cnt == 0) begin
                wb_ack = 1'b1;
                if (wb_we) begin
                    mem[wb_adr[11:2]] = wb_dat_w;
                    wlog_adr.push_back(wb_adr);
                    wlog_dat.push_back(wb_dat_w);
                    wlog_sel.push_back(wb_sel);
                end else begin
                    wb_dat_r = mem[wb_adr[11:2]];
                end
            end else begin
                wait_cnt--;
            end
        end
    end

    // budget grows with each test's length
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt <= budget) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: the core did not halt within %0d cycles", budget);
        $display("SIMULATION FAILED");
        $display("errors: %0d, timeouts: 1", errors);
        $finish;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    function automatic logic [31:0] rtype(input int rs, input int rt, input int rd,
                                          input int sa, input logic [5:0] funct);
        return {6'd0, 5'(rs), 5'(rt), 5'(rd), 5'(sa), funct};
    endfunction

    function automatic logic [31:0] itype(input logic [5:0] op, input int rs, input int rt,
                                          input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic logic [31:0] jtype(input logic [5:0] op, input logic [31:0] adr);
        return {op, adr[27:2]};
    endfunction

    function automatic logic [31:0] fill_word(input int idx);
        return 32'h5a5a_0000 ^ (idx << 2);
    endfunction

    function automatic logic [31:0] sw_op(input int rt, input logic [15:0] off, input int base);
        return itype(6'h2b, base, rt, off);
    endfunction

    // fill memory and load the program around a reset pulse
    task automatic reset_core;
        @(posedge clk);
        #1;
        arst_n = 1'b0;
        wb_ack = 1'b0;
        busy   = 1'b0;
        first_seen = 1'b0;
        bus_cycles = 0;
        wlog_adr.delete();
        wlog_dat.delete();
        wlog_sel.delete();
        for (int i = 0; i < 1024; i++) begin
            mem[i] = fill_word(i);
        end
        foreach (prog[i]) begin
            mem[i] = prog[i];
        end
        budget += 8;
        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;
    endtask

    task automatic run_program;
        budget += prog.size() * 200;
        reset_core();
        while (!halted) begin
            @(posedge clk);
            #1;
        end
    endtask

    // arithmetic program storing its results from 0x800
    task automatic build_arith;
        prog.delete();
        prog.push_back(itype(6'h0d, 0, 30, 16'h0800));
        prog.push_back(itype(6'h0f, 0, 1, 16'h8000));
        prog.push_back(itype(6'h0d, 1, 1, 16'h0005));
        prog.push_back(itype(6'h09, 0, 2, 16'hfffd));
        prog.push_back(itype(6'h0d, 0, 3, 16'h00f0));
        prog.push_back(itype(6'h0d, 0, 16, 16'h0008));
        prog.push_back(rtype(1, 2, 4, 0, 6'h20));
        prog.push_back(rtype(2, 1, 5, 0, 6'h22));
        prog.push_back(rtype(1, 2, 6, 0, 6'h2a));
        prog.push_back(rtype(2, 1, 7, 0, 6'h2b));
        prog.push_back(itype(6'h0c, 2, 8, 16'hff00));
        prog.push_back(itype(6'h0d, 0, 9, 16'h8001));
        prog.push_back(itype(6'h0e, 2, 10, 16'hffff));
        prog.push_back(itype(6'h0f, 0, 11, 16'h1234));
        prog.push_back(rtype(1, 3, 12, 0, 6'h27));
        prog.push_back(rtype(0, 1, 13, 4, 6'h00));
        prog.push_back(rtype(0, 1, 14, 4, 6'h02));
        prog.push_back(rtype(0, 1, 15, 4, 6'h03));
        prog.push_back(rtype(16, 3, 17, 0, 6'h04));
        prog.push_back(rtype(16, 1, 18, 0, 6'h06));
        prog.push_back(rtype(16, 1, 19, 0, 6'h07));
        for (int r = 4; r <= 19; r++) begin
            if (r != 16) begin
                prog.push_back(sw_op(r, 16'((r - 4) * 4), 30));
            end
        end
        prog.push_back(rtype(0, 0, 0, 0, 6'h0d));
    endtask

    task automatic check_arith(input string tag);
        logic [31:0] exp [16];
        // r1 = 8000_0005, r2 = ffff_fffd, r3 = 0000_00f0, shift amounts 4 and 8
        exp[0]  = 32'h8000_0002;
        exp[1]  = 32'h7fff_fff8;
        // r1 is the more negative of the two
        exp[2]  = 32'h0000_0001;
        exp[3]  = 32'h0000_0000;
        exp[4]  = 32'h0000_ff00;
        exp[5]  = 32'h0000_8001;
        exp[6]  = 32'hffff_0002;
        exp[7]  = 32'h1234_0000;
        exp[8]  = 32'h7fff_ff0a;
        exp[9]  = 32'h0000_0050;
        exp[10] = 32'h0800_0000;
        exp[11] = 32'hf800_0000;
        exp[12] = 32'h0000_0000;
        exp[13] = 32'h0000_f000;
        exp[14] = 32'h0080_0000;
        exp[15] = 32'hff80_0000;
        for (int k = 0; k < 16; k++) begin
            if (k != 12) begin
                check($sformatf("%s mem[%0d]", tag, 512 + k), mem[512 + k], exp[k]);
            end
        end
    endtask

    task automatic arith_logic_ops;
        waits_en = 1'b0;
        build_arith();
        run_program();
        check_arith("arith");
    endtask

    task automatic load_store_round_trip;
        prog.delete();
        prog.push_back(itype(6'h0d, 0, 30, 16'h0900));
        prog.push_back(itype(6'h0f, 0, 1, 16'hcafe));
        prog.push_back(itype(6'h0d, 1, 1, 16'hbabe));
        prog.push_back(sw_op(1, 16'd0, 30));
        prog.push_back(itype(6'h23, 30, 2, 16'd0));
        prog.push_back(sw_op(2, 16'd4, 30));
        prog.push_back(itype(6'h09, 30, 3, 16'd16));
        prog.push_back(sw_op(1, 16'hfff8, 3));
        prog.push_back(itype(6'h23, 3, 4, 16'hfff8));
        prog.push_back(sw_op(4, 16'd12, 30));
        prog.push_back(itype(6'h23, 30, 0, 16'd0));
        prog.push_back(sw_op(0, 16'd16, 30));
        prog.push_back(rtype(0, 0, 0, 0, 6'h0d));
        run_program();
        for (int k = 0; k < 4; k++) begin
            check($sformatf("ldst mem[%0d]", 576 + k), mem[576 + k], 32'hcafe_babe);
        end
        check("ldst r0 store", mem[580], 32'd0);
        check("ldst write count", wlog_adr.size(), 32'd5);
        foreach (wlog_adr[i]) begin
            check($sformatf("ldst wb_adr_o write %0d", i), wlog_adr[i], 32'h900 + i * 4);
            check($sformatf("ldst wb_sel_o write %0d", i), {28'd0, wlog_sel[i]}, 32'hf);
            check($sformatf("ldst wb_dat_o write %0d", i), wlog_dat[i],
                  (i < 4) ? 32'hcafe_babe : 32'd0);
        end
    endtask

    function automatic logic branch_taken(input int kind, input logic [31:0] a,
                                          input logic [31:0] b);
        case (kind)
            0: return a == b;
            1: return a != b;
            2: return !a[31];
            3: return !a[31] && a != 0;
            4: return a[31] || a == 0;
            default: return a[31];
        endcase
    endfunction

    task automatic branch_delay_slots;
        logic [31:0] rv [5];
        int          kind [12];
        int          rs [12];
        int          rt [12];
        logic [31:0] skip_exp;
        kind = '{0, 0, 1, 1, 2, 2, 3, 3, 4, 4, 5, 5};
        rs   = '{1, 1, 1, 1, 4, 3, 1, 4, 4, 1, 3, 4};
        rt   = '{2, 3, 3, 2, 0, 0, 0, 0, 0, 0, 0, 0};
        rv   = '{32'd0, 32'd5, 32'd5, 32'hffff_ffff, 32'd0};
        prog.delete();
        prog.push_back(itype(6'h0d, 0, 30, 16'h0a00));
        prog.push_back(itype(6'h0d, 0, 1, 16'd5));
        prog.push_back(itype(6'h0d, 0, 2, 16'd5));
        prog.push_back(itype(6'h09, 0, 3, 16'hffff));
        prog.push_back(itype(6'h0d, 0, 5, 16'd1));
        for (int i = 0; i < 12; i++) begin
            // offset 2 from the delay slot lands past the second store
            case (kind[i])
                0: prog.push_back(itype(6'h04, rs[i], rt[i], 16'd2));
                1: prog.push_back(itype(6'h05, rs[i], rt[i], 16'd2));
                2: prog.push_back(itype(6'h01, rs[i], 1, 16'd2));
                3: prog.push_back(itype(6'h07, rs[i], 0, 16'd2));
                4: prog.push_back(itype(6'h06, rs[i], 0, 16'd2));
                default: prog.push_back(itype(6'h01, rs[i], 0, 16'd2));
            endcase
            prog.push_back(sw_op(5, 16'(i * 8), 30));
            prog.push_back(sw_op(5, 16'(i * 8 + 4), 30));
        end
        prog.push_back(rtype(0, 0, 0, 0, 6'h0d));
        run_program();
        for (int i = 0; i < 12; i++) begin
            skip_exp = branch_taken(kind[i], rv[rs[i]], rv[rt[i]]) ?
                       fill_word(641 + i * 2) : 32'd1;
            check($sformatf("branch %0d delay slot", i), mem[640 + i * 2], 32'd1);
            check($sformatf("branch %0d next", i), mem[641 + i * 2], skip_exp);
        end
    endtask

    task automatic jump_and_link;
        prog.delete();
        prog.push_back(itype(6'h0d, 0, 30, 16'h0b00));
        prog.push_back(itype(6'h0d, 0, 5, 16'd1));
        prog.push_back(jtype(6'h02, 32'h14));
        prog.push_back(sw_op(5, 16'd0, 30));
        prog.push_back(sw_op(5, 16'd4, 30));
        prog.push_back(jtype(6'h03, 32'h20));
        prog.push_back(sw_op(5, 16'd8, 30));
        prog.push_back(sw_op(5, 16'd12, 30));
        prog.push_back(sw_op(31, 16'd16, 30));
        prog.push_back(itype(6'h0d, 0, 6, 16'h34));
        prog.push_back(rtype(6, 0, 0, 0, 6'h08));
        prog.push_back(sw_op(5, 16'd20, 30));
        prog.push_back(sw_op(5, 16'd24, 30));
        prog.push_back(itype(6'h0d, 0, 7, 16'h48));
        prog.push_back(rtype(7, 0, 8, 0, 6'h09));
        prog.push_back(sw_op(5, 16'd28, 30));
        prog.push_back(sw_op(5, 16'd32, 30));
        prog.push_back(sw_op(5, 16'd36, 30));
        prog.push_back(sw_op(8, 16'd40, 30));
        prog.push_back(rtype(0, 0, 0, 0, 6'h0d));
        run_program();
        // delay slots at words 0, 2, 5, 7 and skipped words 1, 3, 6, 8, 9
        check("j delay slot", mem[704], 32'd1);
        check("j skipped", mem[705], fill_word(705));
        check("jal delay slot", mem[706], 32'd1);
        check("jal skipped", mem[707], fill_word(707));
        check("jal r31", mem[708], 32'h14 + 32'd8);
        check("jr delay slot", mem[709], 32'd1);
        check("jr skipped", mem[710], fill_word(710));
        check("jalr delay slot", mem[711], 32'd1);
        check("jalr skipped 1", mem[712], fill_word(712));
        check("jalr skipped 2", mem[713], fill_word(713));
        check("jalr rd", mem[714], 32'h38 + 32'd8);
    endtask

    task automatic reset_and_halt;
        int n;
        prog.delete();
        prog.push_back(itype(6'h0d, 0, 1, 16'd1));
        prog.push_back(rtype(0, 0, 0, 0, 6'h0d));
        budget += prog.size() * 200;
        reset_core();
        check("wb_cyc_o after reset", {31'd0, wb_cyc}, 32'd0);
        check("wb_stb_o after reset", {31'd0, wb_stb}, 32'd0);
        check("halted_o after reset", {31'd0, halted}, 32'd0);
        while (!halted) begin
            @(posedge clk);
            #1;
        end
        check("first fetch wb_adr_o", first_adr, 32'd0);
        n = bus_cycles;
        budget += 20;
        repeat (20) @(posedge clk);
        #1;
        check("bus cycles after break", bus_cycles, n);
        check("wb_cyc_o after break", {31'd0, wb_cyc}, 32'd0);
        check("halted_o after break", {31'd0, halted}, 32'd1);
    endtask

    task automatic wait_state_rerun;
        waits_en = 1'b1;
        build_arith();
        run_program();
        check_arith("waits");
        waits_en = 1'b0;
    endtask

    initial begin
        seed     = 32'h9e8b2508;
        errors   = 0;
        budget   = 20;
        arst_n   = 1'b0;
        wb_ack   = 1'b0;
        wb_dat_r = 32'd0;
        waits_en = 1'b0;
        busy     = 1'b0;
        arith_logic_ops();
        load_store_round_trip();
        branch_delay_slots();
        jump_and_link();
        reset_and_halt();
        wait_state_rerun();
        $display("errors: %0d, timeouts: 0", errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: mips_core.f
verilog/mips_pkg.sv
verilog/inst_decoder.sv
verilog/regfile.sv
verilog/alu.sv
verilog/branch_unit.sv
verilog/core_ctrl.sv
verilog/mips_core.sv
tests/tb_mips_core.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wall -Wno-fatal
TOP       ?= tb_mips_core
FILELIST  ?= mips_core.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
